// ==== src/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// ============================================================
// Core dimensions
// ============================================================

// Datapath width
`define CORE_XLEN 32

// Architectural register count
`define CORE_NREGS 16

// Bits needed to name one register
`define CORE_RIDX 4

`endif

// ==== src/core_pkg.sv ====
`include "core_cfg.svh"

package core_pkg;

  // ARM data-processing opcodes, numbered as in the real encoding
  typedef enum logic [3:0] {
    AND = 4'h0,
    EOR = 4'h1,
    SUB = 4'h2,
    RSB = 4'h3,
    ADD = 4'h4,
    CMP = 4'ha,
    ORR = 4'hc,
    MOV = 4'hd,
    MVN = 4'hf
  } aluOpT;

  typedef enum logic [1:0] {LSL, LSR, ASR, ROR} shiftKindT;

  // Bypass source for a captured operand
  typedef enum logic [1:0] {REGFILE, FROM_EXEC, FROM_WB} fwdSelT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // ============================================================
  // Instruction word
  // ============================================================

  // Immediate form of operand 2, bits 17:12 are zero
  typedef struct packed {
    logic [5:0] unused;
    logic [3:0] rot;
    logic [7:0] imm8;
  } immOpT;

  // Register form of operand 2, rm sits in the low imm8 bits
  typedef struct packed {
    logic [6:0] unused;
    logic [4:0] shAmt;
    shiftKindT  shKind;
    logic [`CORE_RIDX-1:0] rm;
  } regOpT;

  typedef union packed {
    immOpT imm;
    regOpT rg;
  } opnd2T;

  // 4+1+1+4+4+18 = 32 bits
  typedef struct packed {
    aluOpT op;
    logic  setFlags;
    logic  immSel;
    logic [`CORE_RIDX-1:0] rd;
    logic [`CORE_RIDX-1:0] rn;
    opnd2T opnd;
  } instrT;

  // ============================================================
  // Stage payloads
  // ============================================================

  // Decode to execute, operands already bypassed
  typedef struct packed {
    aluOpT op;
    logic  setFlags;
    logic [`CORE_RIDX-1:0] rd;
    logic [`CORE_XLEN-1:0] opA;
    logic [`CORE_XLEN-1:0] opB;
    logic  immSel;
    logic [7:0] imm8;
    logic [3:0] rot;
    shiftKindT shKind;
    logic [4:0] shAmt;
  } execPayT;

  // Retirement record, flags hold the state after this instruction
  typedef struct packed {
    logic [`CORE_RIDX-1:0] rd;
    logic  write;
    logic [`CORE_XLEN-1:0] value;
    flagsT flags;
  } wbT;

endpackage

// ==== src/stageReg.sv ====
`timescale 1ns/1ps

module stageReg #(
  parameter type T = logic [31:0]
) (
  input  logic clk,
  input  logic rstN,
  input  logic en,
  input  logic inVld,
  input  T     inData,
  output logic outVld,
  output T     outData
);

  // Valid bit and payload move together
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outVld  <= 1'b0;
      outData <= '0;
    end else if (en) begin
      outVld  <= inVld;
      outData <= inData;
    end
  end

  // A frozen stage keeps its instruction until the pipe moves again
  holdWhileStalled: assert property (
    @(posedge clk) disable iff (!rstN)
    (!en && outVld) |=> (outVld && $stable(outData))
  ) else $error("stageReg lost or changed a held instruction");

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module regFile (
  input  logic clk,
  input  logic rstN,
  input  logic [`CORE_RIDX-1:0] raddrA,
  input  logic [`CORE_RIDX-1:0] raddrB,
  input  logic we,
  input  logic [`CORE_RIDX-1:0] waddr,
  input  logic [`CORE_XLEN-1:0] wdata,
  output logic [`CORE_XLEN-1:0] rdataA,
  output logic [`CORE_XLEN-1:0] rdataB
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

  // ============================================================
  // Write port
  // ============================================================

  // All registers start at zero
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // ============================================================
  // Read ports
  // ============================================================

  // Same-cycle write is not visible here
  // Decode bypass supplies the new value instead
  assign rdataA = regs[raddrA];
  assign rdataB = regs[raddrB];

  writeAddrKnown: assert property (
    @(posedge clk) disable iff (!rstN)
    we |-> !$isunknown(waddr)
  ) else $error("regFile write with unknown address");

endmodule

// ==== src/barrelShifter.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module barrelShifter import core_pkg::*; (
  input  logic immSel,
  input  logic [7:0] imm8,
  input  logic [3:0] rot,
  input  logic [`CORE_XLEN-1:0] regVal,
  input  shiftKindT shKind,
  input  logic [4:0] shAmt,
  output logic [`CORE_XLEN-1:0] op2
);

  logic [4:0] immAmt;
  logic [2*`CORE_XLEN-1:0] immDbl;
  logic [2*`CORE_XLEN-1:0] immShr;
  logic [2*`CORE_XLEN-1:0] regDbl;
  logic [2*`CORE_XLEN-1:0] regShr;
  logic [`CORE_XLEN-1:0] immVal;
  logic [`CORE_XLEN-1:0] shVal;

  // ============================================================
  // Immediate path
  // ============================================================

  // Rotation is twice the 4-bit field
  assign immAmt = {rot, 1'b0};

  // Doubled word turns a rotate into a plain right shift
  assign immDbl = {{(`CORE_XLEN-8){1'b0}}, imm8, {(`CORE_XLEN-8){1'b0}}, imm8};
  assign immShr = immDbl >> immAmt;
  assign immVal = immShr[`CORE_XLEN-1:0];

  // ============================================================
  // Register path
  // ============================================================

  assign regDbl = {regVal, regVal};
  assign regShr = regDbl >> shAmt;

  // Amount 0 falls through every kind unchanged
  always_comb begin
    unique case (shKind)
      LSL: shVal = regVal << shAmt;
      LSR: shVal = regVal >> shAmt;
      // Sign bit fills from the left
      ASR: shVal = $signed(regVal) >>> shAmt;
      // Low half of the shifted pair is the rotated word
      ROR: shVal = regShr[`CORE_XLEN-1:0];
      default: shVal = regVal;
    endcase
  end

  assign op2 = immSel ? immVal : shVal;

endmodule

// ==== src/aluUnit.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module aluUnit import core_pkg::*; (
  input  aluOpT op,
  input  logic [`CORE_XLEN-1:0] a,
  input  logic [`CORE_XLEN-1:0] b,
  input  flagsT oldFlags,
  output logic [`CORE_XLEN-1:0] result,
  output flagsT flags
);

  logic [`CORE_XLEN-1:0] addX;
  logic [`CORE_XLEN-1:0] addY;
  logic [`CORE_XLEN:0] sum;
  logic isSub;
  logic isArith;

  // ============================================================
  // Shared adder
  // ============================================================

  // RSB swaps the inputs, SUB and CMP invert y and add one
  always_comb begin
    addX  = a;
    addY  = b;
    isSub = 1'b0;
    case (op)
      SUB, CMP: isSub = 1'b1;
      RSB: begin
        addX  = b;
        addY  = ~a;
        isSub = 1'b1;
      end
      default: isSub = 1'b0;
    endcase
    if (isSub && op != RSB) addY = ~b;
  end

  // Carry out doubles as "no borrow" on subtracts
  assign sum = {1'b0, addX} + {1'b0, addY} + {{`CORE_XLEN{1'b0}}, isSub};

  assign isArith = (op == ADD) || (op == SUB) || (op == RSB) || (op == CMP);

  // ============================================================
  // Result select
  // ============================================================

  always_comb begin
    case (op)
      AND: result = a & b;
      EOR: result = a ^ b;
      ORR: result = a | b;
      MOV: result = b;
      MVN: result = ~b;
      default: result = sum[`CORE_XLEN-1:0];
    endcase
  end

  // N and Z always track the result
  assign flags.n = result[`CORE_XLEN-1];
  assign flags.z = (result == '0);
  // Logical ops keep the old C and V
  assign flags.c = isArith ? sum[`CORE_XLEN] : oldFlags.c;
  assign flags.v = isArith ? ((addX[`CORE_XLEN-1] == addY[`CORE_XLEN-1]) &&
                              (sum[`CORE_XLEN-1] != addX[`CORE_XLEN-1]))
                           : oldFlags.v;

  // Unknown op only appears in bubbles before the first instruction
  always_comb begin
    opDefined: assert final ($isunknown(op) ||
                             op inside {AND, EOR, SUB, RSB, ADD, ORR, MOV, MVN, CMP})
      else $error("aluUnit got undefined opcode %h", op);
  end

endmodule

// ==== src/coreControl.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module coreControl import core_pkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic decVld,
  input  instrT decInstr,
  input  logic exeVld,
  input  execPayT exePay,
  input  logic wbVld,
  input  wbT wbRec,
  input  logic resRdy,
  output logic advance,
  output fwdSelT fwdA,
  output fwdSelT fwdB,
  output fwdSelT fwdFlagSel,
  output logic rfWe,
  output flagsT flagReg
);

  logic [`CORE_RIDX-1:0] rn;
  logic [`CORE_RIDX-1:0] rm;
  logic exeWrites;
  logic wbWrites;
  logic resFire;

  // ============================================================
  // Pipeline enable
  // ============================================================

  // Only a full writeback stage facing a busy consumer stalls
  assign advance = !(wbVld && !resRdy);
  assign resFire = wbVld && resRdy;

  // ============================================================
  // Operand bypass
  // ============================================================

  assign rn = decInstr.rn;
  assign rm = decInstr.opnd.rg.rm;

  // CMP never writes and so never forwards
  assign exeWrites = exeVld && (exePay.op != CMP);
  assign wbWrites  = wbVld && wbRec.write;

  // Execute is younger and wins over writeback
  always_comb begin
    fwdA = REGFILE;
    fwdB = REGFILE;
    if (decVld) begin
      if (exeWrites && exePay.rd == rn) fwdA = FROM_EXEC;
      else if (wbWrites && wbRec.rd == rn) fwdA = FROM_WB;

      if (exeWrites && exePay.rd == rm) fwdB = FROM_EXEC;
      else if (wbWrites && wbRec.rd == rm) fwdB = FROM_WB;
    end
  end

  // Flags for the ALU come from the instruction just ahead of it
  assign fwdFlagSel = wbVld ? FROM_WB : REGFILE;

  // ============================================================
  // Architectural updates
  // ============================================================

  assign rfWe = resFire && wbRec.write;

  // Record flags already equal the old state when setFlags was clear
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flagReg <= '0;
    end else if (resFire) begin
      flagReg <= wbRec.flags;
    end
  end

  // A retiring record is fully defined
  retireKnown: assert property (
    @(posedge clk) disable iff (!rstN)
    resFire |-> !$isunknown(wbRec)
  ) else $error("Result handshake with unknown record bits");

endmodule

// ==== src/execCore.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module execCore import core_pkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic inVld,
  output logic inRdy,
  input  instrT inInstr,
  output logic resVld,
  input  logic resRdy,
  output wbT resRec
);

  logic advance;
  logic decVld;
  logic exeVld;
  logic wbVld;
  logic rfWe;
  instrT decInstr;
  execPayT exePayNext;
  execPayT exePay;
  wbT wbNext;
  wbT wbRec;
  fwdSelT fwdA;
  fwdSelT fwdB;
  fwdSelT fwdFlagSel;
  flagsT flagReg;
  flagsT oldFlags;
  flagsT aluFlags;
  logic [`CORE_XLEN-1:0] rdataA;
  logic [`CORE_XLEN-1:0] rdataB;
  logic [`CORE_XLEN-1:0] op2;
  logic [`CORE_XLEN-1:0] aluRes;

  coreControl ctrl (
    .clk(clk), .rstN(rstN),
    .decVld(decVld), .decInstr(decInstr),
    .exeVld(exeVld), .exePay(exePay),
    .wbVld(wbVld), .wbRec(wbRec), .resRdy(resRdy),
    .advance(advance), .fwdA(fwdA), .fwdB(fwdB),
    .fwdFlagSel(fwdFlagSel), .rfWe(rfWe), .flagReg(flagReg)
  );

  assign inRdy = advance;

  // ============================================================
  // Decode
  // ============================================================

  stageReg #(.T(instrT)) decStage (
    .clk(clk), .rstN(rstN), .en(advance),
    .inVld(inVld), .inData(inInstr),
    .outVld(decVld), .outData(decInstr)
  );

  regFile rf (
    .clk(clk), .rstN(rstN),
    .raddrA(decInstr.rn), .raddrB(decInstr.opnd.rg.rm),
    .we(rfWe), .waddr(wbRec.rd), .wdata(wbRec.value),
    .rdataA(rdataA), .rdataB(rdataB)
  );

  // Operand capture with bypass from execute and writeback
  always_comb begin
    exePayNext.op       = decInstr.op;
    exePayNext.setFlags = decInstr.setFlags;
    exePayNext.rd       = decInstr.rd;
    exePayNext.immSel   = decInstr.immSel;
    exePayNext.imm8     = decInstr.opnd.imm.imm8;
    exePayNext.rot      = decInstr.opnd.imm.rot;
    exePayNext.shKind   = decInstr.opnd.rg.shKind;
    exePayNext.shAmt    = decInstr.opnd.rg.shAmt;
    case (fwdA)
      FROM_EXEC: exePayNext.opA = aluRes;
      FROM_WB:   exePayNext.opA = wbRec.value;
      default:   exePayNext.opA = rdataA;
    endcase
    case (fwdB)
      FROM_EXEC: exePayNext.opB = aluRes;
      FROM_WB:   exePayNext.opB = wbRec.value;
      default:   exePayNext.opB = rdataB;
    endcase
  end

  // ============================================================
  // Execute
  // ============================================================

  stageReg #(.T(execPayT)) exeStage (
    .clk(clk), .rstN(rstN), .en(advance),
    .inVld(decVld), .inData(exePayNext),
    .outVld(exeVld), .outData(exePay)
  );

  barrelShifter shifter (
    .immSel(exePay.immSel), .imm8(exePay.imm8), .rot(exePay.rot),
    .regVal(exePay.opB), .shKind(exePay.shKind), .shAmt(exePay.shAmt),
    .op2(op2)
  );

  // Writeback record is the newest flag state if present
  assign oldFlags = (fwdFlagSel == FROM_WB) ? wbRec.flags : flagReg;

  aluUnit alu (
    .op(exePay.op), .a(exePay.opA), .b(op2),
    .oldFlags(oldFlags), .result(aluRes), .flags(aluFlags)
  );

  always_comb begin
    wbNext.rd    = exePay.rd;
    wbNext.write = (exePay.op != CMP);
    wbNext.value = aluRes;
    wbNext.flags = exePay.setFlags ? aluFlags : oldFlags;
  end

  // ============================================================
  // Writeback
  // ============================================================

  stageReg #(.T(wbT)) wbStage (
    .clk(clk), .rstN(rstN), .en(advance),
    .inVld(exeVld), .inData(wbNext),
    .outVld(wbVld), .outData(wbRec)
  );

  assign resVld = wbVld;
  assign resRec = wbRec;

endmodule

// ==== test/execCoreTb.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module execCoreTb import core_pkg::*; ();

  localparam int clkPeriod = 4;
  // Count of directed plus random instructions
  localparam int numInstr = 254;
  localparam int watchdogNs = (numInstr + 50) * clkPeriod * 4;
  localparam int drainLimit = 100;
  localparam aluOpT opList [9] = '{AND, EOR, SUB, RSB, ADD, ORR, MOV, MVN, CMP};

  logic clk;
  logic rstN;
  logic inVld;
  logic inRdy;
  instrT inInstr;
  logic resVld;
  logic resRdy;
  wbT resRec;

  // Reference state updated in program order at acceptance
  logic [`CORE_XLEN-1:0] modelRegs [`CORE_NREGS];
  flagsT modelFlags;
  wbT expQ [$];
  wbT lastRec;
  int valErrs;
  int protoErrs;
  logic sendDone;

  execCore DUT (
    .clk(clk), .rstN(rstN),
    .inVld(inVld), .inRdy(inRdy), .inInstr(inInstr),
    .resVld(resVld), .resRdy(resRdy), .resRec(resRec)
  );

  always #(clkPeriod / 2) clk = ~clk;

  // ============================================================
  // Compare tasks
  // ============================================================

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %0t %s exp %b got %b", $time, name, exp, got);
      valErrs++;
    end
  endtask

  task automatic checkFlags(input string name, input flagsT got, input flagsT exp);
    if (got !== exp) begin
      $display("Fail %0t %s exp %b got %b", $time, name, exp, got);
      valErrs++;
    end
  endtask

  task automatic checkRec(input string name, input wbT got, input wbT exp);
    if (got !== exp) begin
      $display("Fail %0t %s exp rd=%0d w=%b val=%h f=%b got rd=%0d w=%b val=%h f=%b",
               $time, name, exp.rd, exp.write, exp.value, exp.flags,
               got.rd, got.write, got.value, got.flags);
      valErrs++;
    end
  endtask

  // ============================================================
  // Reference model
  // ============================================================

  function automatic logic [31:0] rotr(input logic [31:0] v, input int amt);
    int k;
    k = amt % 32;
    if (k == 0) return v;
    return (v >> k) | (v << (32 - k));
  endfunction

  // Register form of operand 2
  function automatic logic [31:0] shiftVal(input logic [31:0] v, input shiftKindT kind,
                                           input logic [4:0] amt);
    case (kind)
      LSL: return v << amt;
      LSR: return v >> amt;
      ASR: return $unsigned($signed(v) >>> amt);
      default: return rotr(v, amt);
    endcase
  endfunction

  function automatic wbT predictRec(input instrT ins);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [32:0] wide;
    flagsT nf;
    wbT rec;
    a = modelRegs[ins.rn];
    if (ins.immSel) b = rotr({24'd0, ins.opnd.imm.imm8}, 2 * ins.opnd.imm.rot);
    else b = shiftVal(modelRegs[ins.opnd.rg.rm], ins.opnd.rg.shKind, ins.opnd.rg.shAmt);
    // Logical ops start from the old C and V
    nf = modelFlags;
    case (ins.op)
      AND: res = a & b;
      EOR: res = a ^ b;
      ORR: res = a | b;
      MOV: res = b;
      MVN: res = ~b;
      ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        res = wide[31:0];
        nf.c = wide[32];
        nf.v = (a[31] == b[31]) && (res[31] != a[31]);
      end
      RSB: begin
        res = b - a;
        nf.c = (b >= a);
        nf.v = (b[31] != a[31]) && (res[31] != b[31]);
      end
      SUB, CMP: begin
        res = a - b;
        nf.c = (a >= b);
        nf.v = (a[31] != b[31]) && (res[31] != a[31]);
      end
      default: res = '0;
    endcase
    nf.n = res[31];
    nf.z = (res == 32'd0);
    rec.rd = ins.rd;
    rec.write = (ins.op != CMP);
    rec.value = res;
    rec.flags = ins.setFlags ? nf : modelFlags;
    modelFlags = rec.flags;
    if (rec.write) modelRegs[ins.rd] = res;
    return rec;
  endfunction

  // ============================================================
  // Stimulus helpers
  // ============================================================

  function automatic instrT immInstr(input aluOpT op, input logic s, input logic [3:0] rd,
                                     input logic [3:0] rn, input logic [7:0] imm8,
                                     input logic [3:0] rot);
    instrT ins;
    ins = '0;
    ins.op = op;
    ins.setFlags = s;
    ins.immSel = 1'b1;
    ins.rd = rd;
    ins.rn = rn;
    ins.opnd.imm.imm8 = imm8;
    ins.opnd.imm.rot = rot;
    return ins;
  endfunction

  function automatic instrT regInstr(input aluOpT op, input logic s, input logic [3:0] rd,
                                     input logic [3:0] rn, input logic [3:0] rm,
                                     input shiftKindT kind, input logic [4:0] amt);
    instrT ins;
    ins = '0;
    ins.op = op;
    ins.setFlags = s;
    ins.rd = rd;
    ins.rn = rn;
    ins.opnd.rg.rm = rm;
    ins.opnd.rg.shKind = kind;
    ins.opnd.rg.shAmt = amt;
    return ins;
  endfunction

  // Called 1 ns after an edge and returns 1 ns after the accepting edge
  task automatic sendInstr(input instrT ins);
    inVld = 1'b1;
    inInstr = ins;
    @(posedge clk);
    while (!inRdy) @(posedge clk);
    expQ.push_back(predictRec(ins));
    #1;
  endtask

  task automatic stopInput();
    inVld = 1'b0;
  endtask

  task automatic idleCycle();
    inVld = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic waitDrain();
    int cycles;
    cycles = 0;
    while (expQ.size() != 0 && cycles < drainLimit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (expQ.size() != 0) begin
      $display("%0t: %0d expected records never came out", $time, expQ.size());
      protoErrs++;
      expQ.delete();
    end
  endtask

  // Result handshake monitor
  always @(posedge clk) begin
    if (rstN && resVld && resRdy) begin
      if (expQ.size() == 0) begin
        $display("%0t: surplus record for r%0d with no instruction left", $time, resRec.rd);
        protoErrs++;
      end else begin
        checkRec("resRec", resRec, expQ.pop_front());
      end
      lastRec = resRec;
    end
    if (rstN && resVld && !resRdy && inRdy) begin
      $display("%0t: inRdy stayed high while the result port was stalled", $time);
      protoErrs++;
    end
  end

  // ============================================================
  // Directed tests
  // ============================================================

  task automatic testReset();
    checkBit("resVld", resVld, 1'b0);
    checkBit("inRdy", inRdy, 1'b1);
    sendInstr(regInstr(MOV, 1'b1, 4'd1, 4'd0, 4'd0, LSL, 5'd0));
    sendInstr(regInstr(ORR, 1'b0, 4'd2, 4'd3, 4'd4, LSL, 5'd0));
    stopInput();
    waitDrain();
  endtask

  task automatic testImmediate();
    sendInstr(immInstr(MOV, 1'b1, 4'd1, 4'd0, 8'hff, 4'd0));
    sendInstr(immInstr(MOV, 1'b0, 4'd2, 4'd0, 8'h3f, 4'd1));
    sendInstr(immInstr(MOV, 1'b1, 4'd3, 4'd0, 8'h81, 4'd4));
    sendInstr(immInstr(ADD, 1'b1, 4'd4, 4'd1, 8'h01, 4'd15));
    sendInstr(immInstr(ADD, 1'b1, 4'd5, 4'd3, 8'hc0, 4'd8));
    sendInstr(immInstr(MOV, 1'b0, 4'd6, 4'd0, 8'hab, 4'd12));
    stopInput();
    waitDrain();
    // Lone instruction shows its result exactly two edges after acceptance
    sendInstr(immInstr(MOV, 1'b0, 4'd7, 4'd0, 8'h12, 4'd2));
    stopInput();
    @(posedge clk);
    #1;
    checkBit("resVld at n+1", resVld, 1'b0);
    @(posedge clk);
    #1;
    checkBit("resVld at n+2", resVld, 1'b1);
    waitDrain();
  endtask

  task automatic testShifts();
    logic [4:0] amts [3];
    amts = '{5'd0, 5'd1, 5'd31};
    // r2 is negative and r3 positive with high bits set
    sendInstr(immInstr(MVN, 1'b0, 4'd2, 4'd0, 8'h5a, 4'd0));
    sendInstr(immInstr(MOV, 1'b0, 4'd3, 4'd0, 8'hb7, 4'd0));
    sendInstr(regInstr(MOV, 1'b0, 4'd3, 4'd0, 4'd3, LSL, 5'd23));
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < 3; i++) begin
        sendInstr(regInstr(MOV, 1'b1, 4'd4, 4'd0, 4'd2, shiftKindT'(k), amts[i]));
        sendInstr(regInstr(MOV, 1'b1, 4'd4, 4'd0, 4'd3, shiftKindT'(k), amts[i]));
      end
    end
    stopInput();
    waitDrain();
  endtask

  // Distances 1, 2 and 3 hit execute bypass, writeback bypass and the register file
  task automatic testDependencies();
    sendInstr(immInstr(MOV, 1'b0, 4'd1, 4'd0, 8'h03, 4'd0));
    sendInstr(immInstr(ADD, 1'b0, 4'd2, 4'd1, 8'h05, 4'd0));
    sendInstr(regInstr(ADD, 1'b0, 4'd3, 4'd1, 4'd2, LSL, 5'd0));
    sendInstr(regInstr(SUB, 1'b1, 4'd4, 4'd1, 4'd3, LSL, 5'd0));
    sendInstr(regInstr(RSB, 1'b0, 4'd5, 4'd2, 4'd4, LSL, 5'd2));
    sendInstr(regInstr(EOR, 1'b0, 4'd6, 4'd3, 4'd4, LSL, 5'd0));
    sendInstr(regInstr(ORR, 1'b0, 4'd7, 4'd6, 4'd6, ROR, 5'd1));
    sendInstr(regInstr(ADD, 1'b1, 4'd1, 4'd1, 4'd1, LSL, 5'd0));
    sendInstr(regInstr(MVN, 1'b0, 4'd8, 4'd0, 4'd1, LSL, 5'd0));
    stopInput();
    waitDrain();
  endtask

  task automatic testFlags();
    wbT exp;
    sendInstr(immInstr(MOV, 1'b0, 4'd5, 4'd0, 8'h07, 4'd0));
    sendInstr(immInstr(MOV, 1'b0, 4'd6, 4'd0, 8'h07, 4'd0));
    sendInstr(regInstr(CMP, 1'b1, 4'd5, 4'd5, 4'd6, LSL, 5'd0));
    stopInput();
    waitDrain();
    // Equal gives Z and no borrow
    checkFlags("flags cmp equal", lastRec.flags, flagsT'(4'b0110));
    checkBit("cmp write", lastRec.write, 1'b0);
    sendInstr(regInstr(MOV, 1'b0, 4'd10, 4'd0, 4'd5, LSL, 5'd0));
    stopInput();
    waitDrain();
    exp.rd = 4'd10;
    exp.write = 1'b1;
    exp.value = 32'd7;
    exp.flags = flagsT'(4'b0110);
    checkRec("cmp target r5", lastRec, exp);
    // 7 minus 9 borrows
    sendInstr(immInstr(CMP, 1'b1, 4'd5, 4'd5, 8'h09, 4'd0));
    stopInput();
    waitDrain();
    checkFlags("flags cmp borrow", lastRec.flags, flagsT'(4'b1000));
    // Most negative minus one overflows
    sendInstr(immInstr(MOV, 1'b0, 4'd7, 4'd0, 8'h01, 4'd0));
    sendInstr(regInstr(MOV, 1'b0, 4'd7, 4'd0, 4'd7, LSL, 5'd31));
    sendInstr(immInstr(SUB, 1'b1, 4'd8, 4'd7, 8'h01, 4'd0));
    stopInput();
    waitDrain();
    checkFlags("flags sub overflow", lastRec.flags, flagsT'(4'b0011));
    sendInstr(regInstr(AND, 1'b1, 4'd9, 4'd8, 4'd8, LSL, 5'd0));
    stopInput();
    waitDrain();
    checkFlags("flags and keeps cv", lastRec.flags, flagsT'(4'b0011));
  endtask

  task automatic testBackPressure();
    aluOpT op;
    sendDone = 1'b0;
    fork
      begin
        for (int i = 0; i < 200; i++) begin
          op = opList[$urandom_range(8)];
          if ($urandom_range(1))
            sendInstr(immInstr(op, 1'($urandom_range(1)), 4'($urandom_range(15)),
                               4'($urandom_range(15)), 8'($urandom_range(255)),
                               4'($urandom_range(15))));
          else
            sendInstr(regInstr(op, 1'($urandom_range(1)), 4'($urandom_range(15)),
                               4'($urandom_range(15)), 4'($urandom_range(15)),
                               shiftKindT'($urandom_range(3)), 5'($urandom_range(31))));
          if ($urandom_range(3) == 0) idleCycle();
        end
        stopInput();
        sendDone = 1'b1;
      end
      begin
        while (!sendDone) begin
          resRdy = 1'($urandom_range(1));
          @(posedge clk);
          #1;
        end
      end
    join
    resRdy = 1'b1;
    waitDrain();
    // Extra cycles let a duplicated last record show up
    repeat (4) idleCycle();
  endtask

  // ============================================================
  // Main sequence and watchdog
  // ============================================================

  initial begin
    void'($urandom(32'hf54b8011));
    clk = 1'b0;
    rstN = 1'b0;
    inVld = 1'b0;
    inInstr = '0;
    resRdy = 1'b1;
    sendDone = 1'b0;
    valErrs = 0;
    protoErrs = 0;
    modelFlags = '0;
    lastRec = '0;
    for (int i = 0; i < `CORE_NREGS; i++) modelRegs[i] = '0;
    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;
    testReset();
    testImmediate();
    testShifts();
    testDependencies();
    testFlags();
    testBackPressure();
    $display("errors: value %0d, protocol %0d", valErrs, protoErrs);
    if (valErrs == 0 && protoErrs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdogNs);
    $display("Run did not finish within %0d ns", watchdogNs);
    $display("errors: value %0d, protocol %0d", valErrs, protoErrs);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+src
src/core_pkg.sv
src/stageReg.sv
src/regFile.sv
src/barrelShifter.sv
src/aluUnit.sv
src/coreControl.sv
src/execCore.sv
test/execCoreTb.sv
